// File: hdl/fifo_loopback_pkg.sv
package fifo_loopback_pkg;

  //////////////////////////////
  // Stream format
  //////////////////////////////

  // I in the upper half, Q in the lower half
  localparam int SAMPLE_W = 32;
  localparam int HALF_W   = SAMPLE_W / 2;

  // Per-sample operation applied in each lane
  typedef enum logic [1:0] {
    OP_PASS    = 2'd0,
    OP_NEGATE  = 2'd1,
    OP_SWAP_IQ = 2'd2,
    OP_CONJ    = 2'd3
  } op_e;

  //////////////////////////////
  // Register bank
  //////////////////////////////

  localparam int AXIL_ADDR_W = 4;
  localparam int AXIL_DATA_W = 32;

  // Byte offsets
  localparam logic [AXIL_ADDR_W-1:0] REG_ID        = 4'h0;
  localparam logic [AXIL_ADDR_W-1:0] REG_CTRL      = 4'h4;
  localparam logic [AXIL_ADDR_W-1:0] REG_PKT_COUNT = 4'h8;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// File: hdl/axil_settings_regs.sv
`timescale 1ns/1ns

module axil_settings_regs
  import fifo_loopback_pkg::*;
#(
  parameter logic [63:0] NOC_ID = 64'hF1F0_0000_0000_0000
) (
  input  logic                   ce_clk,
  input  logic                   i_rst_n,
  input  logic                   i_pkt_done,
  // Write address
  input  logic [AXIL_ADDR_W-1:0] i_s_axil_awaddr,
  input  logic                   i_s_axil_awvalid,
  output logic                   o_s_axil_awready,
  // Write data
  input  logic [AXIL_DATA_W-1:0] i_s_axil_wdata,
  input  logic [3:0]             i_s_axil_wstrb,
  input  logic                   i_s_axil_wvalid,
  output logic                   o_s_axil_wready,
  // Write response
  output axi_resp_e              o_s_axil_bresp,
  output logic                   o_s_axil_bvalid,
  input  logic                   i_s_axil_bready,
  // Read address
  input  logic [AXIL_ADDR_W-1:0] i_s_axil_araddr,
  input  logic                   i_s_axil_arvalid,
  output logic                   o_s_axil_arready,
  // Read data
  output logic [AXIL_DATA_W-1:0] o_s_axil_rdata,
  output axi_resp_e              o_s_axil_rresp,
  output logic                   o_s_axil_rvalid,
  input  logic                   i_s_axil_rready,
  output op_e                    o_opcode
);

  logic                   wr_accept;
  logic                   rd_accept;
  axi_resp_e              wr_resp;
  axi_resp_e              rd_resp;
  logic [AXIL_DATA_W-1:0] rd_data;
  op_e                    ctrl_op;
  logic [31:0]            pkt_count;

  // Address and data must arrive together, one outstanding response
  assign wr_accept        = i_s_axil_awvalid & i_s_axil_wvalid & ~o_s_axil_bvalid;
  assign rd_accept        = i_s_axil_arvalid & ~o_s_axil_rvalid;
  assign o_s_axil_awready = wr_accept;
  assign o_s_axil_wready  = wr_accept;
  assign o_s_axil_arready = ~o_s_axil_rvalid;
  assign o_opcode         = ctrl_op;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  always_comb begin
    case (i_s_axil_awaddr)
      REG_ID, REG_CTRL, REG_PKT_COUNT: wr_resp = RESP_OKAY;
      default:                         wr_resp = RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (i_s_axil_araddr)
      REG_ID:        rd_data = NOC_ID[31:0];
      REG_CTRL:      rd_data = {{(AXIL_DATA_W-2){1'b0}}, ctrl_op};
      REG_PKT_COUNT: rd_data = pkt_count;
      default:       rd_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_s_axil_bvalid <= 1'b0;
      o_s_axil_rvalid <= 1'b0;
      ctrl_op         <= OP_PASS;
      pkt_count       <= '0;
    end else begin
      if (wr_accept) begin
        o_s_axil_bvalid <= 1'b1;
      end else if (i_s_axil_bready) begin
        o_s_axil_bvalid <= 1'b0;
      end
      if (rd_accept) begin
        o_s_axil_rvalid <= 1'b1;
      end else if (i_s_axil_rready) begin
        o_s_axil_rvalid <= 1'b0;
      end
      // Only CTRL is writable, ID and count ignore writes
      if (wr_accept && i_s_axil_awaddr == REG_CTRL && i_s_axil_wstrb[0]) begin
        ctrl_op <= op_e'(i_s_axil_wdata[1:0]);
      end
      if (i_pkt_done) begin
        pkt_count <= pkt_count + 32'd1;
      end
    end
  end

  // Response payload
  always_ff @(posedge ce_clk) begin
    if (wr_accept) begin
      o_s_axil_bresp <= wr_resp;
    end
    if (rd_accept) begin
      o_s_axil_rdata <= rd_data;
      o_s_axil_rresp <= rd_resp;
    end
  end

  a_bvalid_hold: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    o_s_axil_bvalid && !i_s_axil_bready |=> o_s_axil_bvalid && $stable(o_s_axil_bresp));

  a_rvalid_hold: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    o_s_axil_rvalid && !i_s_axil_rready |=> o_s_axil_rvalid && $stable(o_s_axil_rdata));

endmodule

// File: hdl/packet_dispatcher.sv
`timescale 1ns/1ns

module packet_dispatcher
  import fifo_loopback_pkg::*;
#(
  parameter int NUM_LANES = 4,
  parameter int LANE_W    = 2
) (
  input  logic                 ce_clk,
  input  logic                 i_rst_n,
  input  logic [SAMPLE_W-1:0]  i_tdata,
  input  logic                 i_tlast,
  input  logic                 i_tvalid,
  output logic                 o_tready,
  output logic [SAMPLE_W-1:0]  o_lane_tdata,
  output logic                 o_lane_tlast,
  output logic [NUM_LANES-1:0] o_lane_tvalid,
  input  logic [NUM_LANES-1:0] i_lane_tready
);

  logic [LANE_W-1:0] lane_ptr;
  logic              last_beat;

  // Data fans out to every lane, only valid is steered
  assign o_lane_tdata = i_tdata;
  assign o_lane_tlast = i_tlast;

  always_comb begin
    o_lane_tvalid           = '0;
    o_lane_tvalid[lane_ptr] = i_tvalid;
  end

  // A full selected lane stalls the input even if others have room
  assign o_tready  = i_lane_tready[lane_ptr];
  assign last_beat = i_tvalid & o_tready & i_tlast;

  // Move to the next lane once the packet is complete
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lane_ptr <= '0;
    end else if (last_beat) begin
      if (lane_ptr == LANE_W'(NUM_LANES - 1)) begin
        lane_ptr <= '0;
      end else begin
        lane_ptr <= lane_ptr + 1'b1;
      end
    end
  end

  a_one_lane_valid: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    $onehot0(o_lane_tvalid));

endmodule

// File: hdl/lane_fifo.sv
`timescale 1ns/1ns

module lane_fifo
  import fifo_loopback_pkg::*;
#(
  parameter int LANE_DEPTH = 16
) (
  input  logic                ce_clk,
  input  logic                i_rst_n,
  input  op_e                 i_opcode,
  input  logic [SAMPLE_W-1:0] i_tdata,
  input  logic                i_tlast,
  input  logic                i_tvalid,
  output logic                o_tready,
  output logic [SAMPLE_W-1:0] o_tdata,
  output logic                o_tlast,
  output logic                o_tvalid,
  input  logic                i_tready
);

  localparam int PTR_W = $clog2(LANE_DEPTH);
  localparam logic [PTR_W:0] DEPTH_CNT = LANE_DEPTH[PTR_W:0];

  // tlast kept in the top bit of each entry
  logic [SAMPLE_W:0] mem [LANE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;
  logic              wr_en;
  logic              rd_en;

  function automatic logic [SAMPLE_W-1:0] apply_op(op_e op, logic [SAMPLE_W-1:0] sample);
    logic [HALF_W-1:0] re;
    logic [HALF_W-1:0] im;
    re = sample[SAMPLE_W-1:HALF_W];
    im = sample[HALF_W-1:0];
    case (op)
      OP_NEGATE:  return {-re, -im};
      OP_SWAP_IQ: return {im, re};
      OP_CONJ:    return {re, -im};
      default:    return sample;
    endcase
  endfunction

  assign o_tready = (count != DEPTH_CNT);
  assign o_tvalid = (count != '0);
  assign wr_en    = i_tvalid & o_tready;
  assign rd_en    = o_tvalid & i_tready;
  assign o_tdata  = mem[rd_ptr][SAMPLE_W-1:0];
  assign o_tlast  = mem[rd_ptr][SAMPLE_W];

  always_ff @(posedge ce_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {i_tlast, apply_op(i_opcode, i_tdata)};
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_write_full: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    count == DEPTH_CNT && !rd_en |=> count == DEPTH_CNT && wr_ptr == rd_ptr);

  a_no_read_empty: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    count == '0 && !wr_en |=> count == '0 && $stable(rd_ptr));

endmodule

// File: hdl/packet_merger.sv
`timescale 1ns/1ns

module packet_merger
  import fifo_loopback_pkg::*;
#(
  parameter int NUM_LANES = 4,
  parameter int LANE_W    = 2
) (
  input  logic                               ce_clk,
  input  logic                               i_rst_n,
  input  logic [NUM_LANES-1:0][SAMPLE_W-1:0] i_lane_tdata,
  input  logic [NUM_LANES-1:0]               i_lane_tlast,
  input  logic [NUM_LANES-1:0]               i_lane_tvalid,
  output logic [NUM_LANES-1:0]               o_lane_tready,
  output logic [SAMPLE_W-1:0]                o_tdata,
  output logic                               o_tlast,
  output logic                               o_tvalid,
  input  logic                               i_tready,
  output logic                               o_pkt_done
);

  logic [LANE_W-1:0] lane_ptr;
  logic              last_beat;

  // Same rotation as the dispatcher keeps packet order
  assign o_tdata  = i_lane_tdata[lane_ptr];
  assign o_tlast  = i_lane_tlast[lane_ptr];
  assign o_tvalid = i_lane_tvalid[lane_ptr];

  always_comb begin
    o_lane_tready           = '0;
    o_lane_tready[lane_ptr] = i_tready;
  end

  assign last_beat = o_tvalid & i_tready & o_tlast;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      lane_ptr   <= '0;
      o_pkt_done <= 1'b0;
    end else begin
      o_pkt_done <= last_beat;
      if (last_beat) begin
        lane_ptr <= (lane_ptr == LANE_W'(NUM_LANES - 1)) ? '0 : lane_ptr + 1'b1;
      end
    end
  end

  a_one_lane_ready: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    $onehot0(o_lane_tready));

endmodule

// File: hdl/noc_block_fifo_loopback.sv
`timescale 1ns/1ns

module noc_block_fifo_loopback
  import fifo_loopback_pkg::*;
#(
  parameter logic [63:0] NOC_ID     = 64'hF1F0_0000_0000_0000,
  parameter int          NUM_LANES  = 4,
  parameter int          LANE_DEPTH = 16
) (
  input  logic                   ce_clk,
  input  logic                   i_rst_n,
  // Stream in
  input  logic [SAMPLE_W-1:0]    i_tdata,
  input  logic                   i_tlast,
  input  logic                   i_tvalid,
  output logic                   o_tready,
  // Stream out
  output logic [SAMPLE_W-1:0]    o_tdata,
  output logic                   o_tlast,
  output logic                   o_tvalid,
  input  logic                   i_tready,
  // Register bank
  input  logic [AXIL_ADDR_W-1:0] i_s_axil_awaddr,
  input  logic                   i_s_axil_awvalid,
  output logic                   o_s_axil_awready,
  input  logic [AXIL_DATA_W-1:0] i_s_axil_wdata,
  input  logic [3:0]             i_s_axil_wstrb,
  input  logic                   i_s_axil_wvalid,
  output logic                   o_s_axil_wready,
  output axi_resp_e              o_s_axil_bresp,
  output logic                   o_s_axil_bvalid,
  input  logic                   i_s_axil_bready,
  input  logic [AXIL_ADDR_W-1:0] i_s_axil_araddr,
  input  logic                   i_s_axil_arvalid,
  output logic                   o_s_axil_arready,
  output logic [AXIL_DATA_W-1:0] o_s_axil_rdata,
  output axi_resp_e              o_s_axil_rresp,
  output logic                   o_s_axil_rvalid,
  input  logic                   i_s_axil_rready
);

  localparam int LANE_W = $clog2(NUM_LANES);

  op_e                                opcode;
  logic                               pkt_done;
  logic [SAMPLE_W-1:0]                lane_in_tdata;
  logic                               lane_in_tlast;
  logic [NUM_LANES-1:0]               lane_in_tvalid;
  logic [NUM_LANES-1:0]               lane_in_tready;
  logic [NUM_LANES-1:0][SAMPLE_W-1:0] lane_out_tdata;
  logic [NUM_LANES-1:0]               lane_out_tlast;
  logic [NUM_LANES-1:0]               lane_out_tvalid;
  logic [NUM_LANES-1:0]               lane_out_tready;

  //////////////////////////////
  // Register bank
  //////////////////////////////

  axil_settings_regs #(.NOC_ID(NOC_ID)) u_regs (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_pkt_done(pkt_done),
    .i_s_axil_awaddr(i_s_axil_awaddr), .i_s_axil_awvalid(i_s_axil_awvalid),
    .o_s_axil_awready(o_s_axil_awready),
    .i_s_axil_wdata(i_s_axil_wdata), .i_s_axil_wstrb(i_s_axil_wstrb),
    .i_s_axil_wvalid(i_s_axil_wvalid), .o_s_axil_wready(o_s_axil_wready),
    .o_s_axil_bresp(o_s_axil_bresp), .o_s_axil_bvalid(o_s_axil_bvalid),
    .i_s_axil_bready(i_s_axil_bready),
    .i_s_axil_araddr(i_s_axil_araddr), .i_s_axil_arvalid(i_s_axil_arvalid),
    .o_s_axil_arready(o_s_axil_arready),
    .o_s_axil_rdata(o_s_axil_rdata), .o_s_axil_rresp(o_s_axil_rresp),
    .o_s_axil_rvalid(o_s_axil_rvalid), .i_s_axil_rready(i_s_axil_rready),
    .o_opcode(opcode));

  //////////////////////////////
  // Lane datapath
  //////////////////////////////

  packet_dispatcher #(.NUM_LANES(NUM_LANES), .LANE_W(LANE_W)) u_dispatch (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n),
    .i_tdata(i_tdata), .i_tlast(i_tlast), .i_tvalid(i_tvalid), .o_tready(o_tready),
    .o_lane_tdata(lane_in_tdata), .o_lane_tlast(lane_in_tlast),
    .o_lane_tvalid(lane_in_tvalid), .i_lane_tready(lane_in_tready));

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    lane_fifo #(.LANE_DEPTH(LANE_DEPTH)) u_lane (
      .ce_clk(ce_clk), .i_rst_n(i_rst_n), .i_opcode(opcode),
      .i_tdata(lane_in_tdata), .i_tlast(lane_in_tlast),
      .i_tvalid(lane_in_tvalid[g]), .o_tready(lane_in_tready[g]),
      .o_tdata(lane_out_tdata[g]), .o_tlast(lane_out_tlast[g]),
      .o_tvalid(lane_out_tvalid[g]), .i_tready(lane_out_tready[g]));
  end

  packet_merger #(.NUM_LANES(NUM_LANES), .LANE_W(LANE_W)) u_merge (
    .ce_clk(ce_clk), .i_rst_n(i_rst_n),
    .i_lane_tdata(lane_out_tdata), .i_lane_tlast(lane_out_tlast),
    .i_lane_tvalid(lane_out_tvalid), .o_lane_tready(lane_out_tready),
    .o_tdata(o_tdata), .o_tlast(o_tlast), .o_tvalid(o_tvalid), .i_tready(i_tready),
    .o_pkt_done(pkt_done));

endmodule

// File: test/tb_noc_block_fifo_loopback.sv
`timescale 1ns/1ns

module tb_noc_block_fifo_loopback
  import fifo_loopback_pkg::*;
;

  localparam logic [63:0] TB_NOC_ID = 64'hF1F0_0000_0000_0000;
  // 40 packets of up to 16 beats at half rate, plus bus traffic, times four
  localparam int MAX_CYCLES = 20000;
  // Four full lanes of 16 beats drain well inside this
  localparam int DRAIN_LIMIT = 200;

  logic ce_clk = 1'b0;
  logic i_rst_n = 1'b0;
  logic [31:0] i_tdata = '0;
  logic i_tlast = 1'b0;
  logic i_tvalid = 1'b0;
  logic o_tready;
  logic [31:0] o_tdata;
  logic o_tlast;
  logic o_tvalid;
  logic i_tready = 1'b1;
  logic [3:0] i_s_axil_awaddr = '0;
  logic i_s_axil_awvalid = 1'b0;
  logic o_s_axil_awready;
  logic [31:0] i_s_axil_wdata = '0;
  logic [3:0] i_s_axil_wstrb = '0;
  logic i_s_axil_wvalid = 1'b0;
  logic o_s_axil_wready;
  axi_resp_e o_s_axil_bresp;
  logic o_s_axil_bvalid;
  logic i_s_axil_bready = 1'b0;
  logic [3:0] i_s_axil_araddr = '0;
  logic i_s_axil_arvalid = 1'b0;
  logic o_s_axil_arready;
  logic [31:0] o_s_axil_rdata;
  axi_resp_e o_s_axil_rresp;
  logic o_s_axil_rvalid;
  logic i_s_axil_rready = 1'b0;

  logic [32:0] exp_q[$];
  op_e cur_op = OP_PASS;
  string cur_test = "reset_id";
  bit bp_on = 1'b0;
  int errors = 0;
  int n_pass = 0;
  int n_fail = 0;
  int cycles = 0;
  int tlast_seen = 0;
  logic chk_fire = 1'b0;
  logic chk_miss = 1'b0;
  logic [32:0] chk_exp = '0;
  logic [32:0] chk_act = '0;

  noc_block_fifo_loopback #(.NOC_ID(TB_NOC_ID)) DUT (.*);

  always #2 ce_clk = ~ce_clk;

  always @(negedge ce_clk) begin
    i_tready <= bp_on ? ($urandom_range(1, 0) == 1) : 1'b1;
  end

  always @(posedge ce_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // Expected sample from the I/Q operation rules
  function automatic logic [31:0] model_sample(op_e op, logic [31:0] s);
    logic [15:0] i_part;
    logic [15:0] q_part;
    i_part = s[31:16];
    q_part = s[15:0];
    if (op == OP_NEGATE) begin
      return {16'h0 - i_part, 16'h0 - q_part};
    end else if (op == OP_SWAP_IQ) begin
      return {q_part, i_part};
    end else if (op == OP_CONJ) begin
      return {i_part, 16'h0 - q_part};
    end
    return s;
  endfunction

  //////////////////////////////
  // Reference queue and monitor
  //////////////////////////////

  always @(posedge ce_clk) begin
    if (i_rst_n) begin
      if (i_tvalid && o_tready) begin
        exp_q.push_back({i_tlast, model_sample(cur_op, i_tdata)});
      end
      chk_fire <= o_tvalid && i_tready;
      if (o_tvalid && i_tready) begin
        chk_act  <= {o_tlast, o_tdata};
        chk_miss <= (exp_q.size() == 0);
        if (exp_q.size() != 0) begin
          chk_exp <= exp_q.pop_front();
        end
        if (o_tlast) begin
          tlast_seen++;
        end
      end
    end
  end

  // Checked half a cycle later, when the captured beat is stable
  a_beat_match: assert property (@(negedge ce_clk) disable iff (!i_rst_n)
    chk_fire |-> !chk_miss && chk_act == chk_exp)
    else begin
      errors++;
      if (chk_miss) begin
        $display("%s: output beat %h arrived with nothing expected", cur_test, chk_act);
      end else begin
        $display("FAIL %s beat expected %h actual %h", cur_test, chk_exp, chk_act);
      end
    end

  // Write address and write data are taken together
  a_aw_w_ready: assert property (@(negedge ce_clk) disable iff (!i_rst_n)
    o_s_axil_wready == o_s_axil_awready)
    else begin
      errors++;
      $display("%s: write address ready and write data ready differ", cur_test);
    end

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act)
      else begin
        errors++;
        $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
      end
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output axi_resp_e resp);
    i_s_axil_awaddr  = addr;
    i_s_axil_wdata   = data;
    i_s_axil_wstrb   = 4'hF;
    i_s_axil_awvalid = 1'b1;
    i_s_axil_wvalid  = 1'b1;
    i_s_axil_bready  = 1'b1;
    @(posedge ce_clk);
    while (!o_s_axil_awready) @(posedge ce_clk);
    @(negedge ce_clk);
    i_s_axil_awvalid = 1'b0;
    i_s_axil_wvalid  = 1'b0;
    while (!o_s_axil_bvalid) @(negedge ce_clk);
    resp = o_s_axil_bresp;
    @(negedge ce_clk);
    i_s_axil_bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output axi_resp_e resp);
    i_s_axil_araddr  = addr;
    i_s_axil_arvalid = 1'b1;
    i_s_axil_rready  = 1'b1;
    @(posedge ce_clk);
    while (!o_s_axil_arready) @(posedge ce_clk);
    @(negedge ce_clk);
    i_s_axil_arvalid = 1'b0;
    while (!o_s_axil_rvalid) @(negedge ce_clk);
    data = o_s_axil_rdata;
    resp = o_s_axil_rresp;
    @(negedge ce_clk);
    i_s_axil_rready = 1'b0;
  endtask

  task automatic send_packet(input int len, input bit gaps);
    for (int b = 0; b < len; b++) begin
      if (gaps) begin
        repeat ($urandom_range(2, 0)) @(negedge ce_clk);
      end
      i_tdata  = $urandom;
      i_tlast  = (b == len - 1);
      i_tvalid = 1'b1;
      @(posedge ce_clk);
      while (!o_tready) @(posedge ce_clk);
      @(negedge ce_clk);
      i_tvalid = 1'b0;
    end
  endtask

  task automatic set_op(input op_e op);
    axi_resp_e resp;
    logic [31:0] rd;
    axil_write(REG_CTRL, 32'(op), resp);
    cur_op = op;
    check_eq("ctrl write resp", 32'(RESP_OKAY), 32'(resp));
    axil_read(REG_CTRL, rd, resp);
    check_eq("ctrl readback", 32'(op), rd);
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge ce_clk);
      waited++;
    end
    repeat (4) @(negedge ce_clk);
    check_eq("queue left", 32'h0, exp_q.size());
  endtask

  task automatic finish_test(input int err_before);
    if (errors == err_before) begin
      n_pass++;
      $display("%s: ok", cur_test);
    end else begin
      n_fail++;
      $display("%s: %0d errors", cur_test, errors - err_before);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int err0;
    logic [31:0] rd;
    logic [31:0] count_before;
    axi_resp_e resp;
    void'($urandom(30));
    repeat (2) @(negedge ce_clk);
    i_rst_n = 1'b1;

    err0 = errors;
    check_eq("o_tvalid", 32'h0, 32'(o_tvalid));
    check_eq("bvalid", 32'h0, 32'(o_s_axil_bvalid));
    check_eq("rvalid", 32'h0, 32'(o_s_axil_rvalid));
    axil_read(REG_ID, rd, resp);
    check_eq("id", TB_NOC_ID[31:0], rd);
    check_eq("id resp", 32'(RESP_OKAY), 32'(resp));
    axil_read(REG_CTRL, rd, resp);
    check_eq("ctrl", 32'(OP_PASS), rd);
    check_eq("ctrl resp", 32'(RESP_OKAY), 32'(resp));
    finish_test(err0);

    cur_test = "pass_loopback";
    err0 = errors;
    repeat (12) send_packet($urandom_range(16, 1), 1'b0);
    wait_drained();
    finish_test(err0);

    cur_test = "operations";
    err0 = errors;
    set_op(OP_NEGATE);
    send_packet($urandom_range(16, 1), 1'b0);
    wait_drained();
    set_op(OP_SWAP_IQ);
    send_packet($urandom_range(16, 1), 1'b0);
    wait_drained();
    set_op(OP_CONJ);
    send_packet($urandom_range(16, 1), 1'b0);
    wait_drained();
    finish_test(err0);

    cur_test = "backpressure";
    err0 = errors;
    set_op(OP_PASS);
    bp_on = 1'b1;
    repeat (25) send_packet($urandom_range(16, 1), 1'b1);
    bp_on = 1'b0;
    wait_drained();
    finish_test(err0);

    cur_test = "registers";
    err0 = errors;
    axil_read(REG_PKT_COUNT, count_before, resp);
    check_eq("pkt count", tlast_seen, count_before);
    check_eq("pkt count resp", 32'(RESP_OKAY), 32'(resp));
    axil_write(REG_PKT_COUNT, 32'hFFFF, resp);
    check_eq("count write resp", 32'(RESP_OKAY), 32'(resp));
    axil_read(REG_PKT_COUNT, rd, resp);
    check_eq("count after write", count_before, rd);
    axil_read(4'hC, rd, resp);
    check_eq("bad offset resp", 32'(RESP_SLVERR), 32'(resp));
    finish_test(err0);

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0 && errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: noc_block_fifo_loopback.f
hdl/fifo_loopback_pkg.sv
hdl/axil_settings_regs.sv
hdl/packet_dispatcher.sv
hdl/lane_fifo.sv
hdl/packet_merger.sv
hdl/noc_block_fifo_loopback.sv
test/tb_noc_block_fifo_loopback.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f noc_block_fifo_loopback.f \
  --top-module tb_noc_block_fifo_loopback -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
